//--- list.f
design/osd_pkg.sv
design/osd_raster.sv
design/osd_ram.sv
design/osd_bus_regs.sv
design/osd_pixel_mixer.sv
design/osd_top.sv
verification/tb_osd_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the osd testbench with verilator and runs it
# exit status is zero only when the pass line is printed

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
  --top-module tb_osd_top -f list.f -o sim_osd \
  && ./obj_dir/sim_osd | tee /dev/stderr | grep -F -x '=== PASS ===' > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- verification/tb_osd_top.sv
//////////////////////////////////////////////////
// testbench for the osd top level
// runs a bus op table, loads a random bitmap and
// checks every video pixel against a byte model
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_osd_top;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam logic [23:0] FG  = 24'hf0_e8_d0;
  localparam logic [23:0] BG  = 24'h1c_2a_3e;

  // window and frame shape
  localparam int WIN_W     = int'(osd_pkg::OSD_W_PIX);
  localparam int WIN_H     = int'(osd_pkg::OSD_H_PIX);
  localparam int LINES     = 70;
  localparam int PIX       = 300;
  localparam int LINE_CYC  = PIX + 4;
  localparam int FRAME_CYC = 1 + LINES * LINE_CYC;
  localparam int N_FRAMES  = 4;

  // bus op budget
  localparam int OP_BOUND  = 32;
  localparam int N_OPS     = 17;
  localparam int N_READS   = 64;
  localparam int TOTAL_OPS = N_OPS + int'(osd_pkg::OSD_WORDS) + N_READS + 2;
  localparam int WD_CYCLES = RESET_CYCLES + TOTAL_OPS * (OP_BOUND + 4)
                             + N_FRAMES * FRAME_CYC + 100;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] exp;
  } bus_op_t;

  // zero strobe is a read checked against exp
  localparam bus_op_t OPS [N_OPS] = '{
    '{32'h1000_0000, 32'ha5a5_5a5a, 4'b1111, 32'h0000_0000},
    '{32'h1000_0000, 32'h0000_0000, 4'b0000, 32'ha5a5_5a5a},
    '{32'h1000_0000, 32'h0000_3c00, 4'b0010, 32'h0000_0000},
    '{32'h1000_0000, 32'h0000_0000, 4'b0000, 32'ha5a5_3c5a},
    '{32'h1000_07fc, 32'h1234_5678, 4'b1111, 32'h0000_0000},
    '{32'h1000_07fc, 32'hee00_0000, 4'b1000, 32'h0000_0000},
    '{32'h1000_07fc, 32'h0000_0000, 4'b0000, 32'hee34_5678},
    '{32'h1000_0000, 32'h0000_0000, 4'b0000, 32'ha5a5_3c5a},
    '{32'h3000_0000, 32'h0000_0001, 4'b1111, 32'h0000_0000},
    '{32'h3000_0000, 32'h0000_0000, 4'b0000, 32'h0000_0001},
    '{32'h3000_0000, 32'h0000_0000, 4'b0001, 32'h0000_0000},
    '{32'h3000_0000, 32'h0000_0000, 4'b0000, 32'h0000_0001},
    '{32'h2000_0040, 32'h0000_0000, 4'b0000, 32'h0000_0000},
    '{32'h5000_0000, 32'hffff_ffff, 4'b1111, 32'h0000_0000},
    '{32'h3000_0004, 32'h0000_0000, 4'b0000, 32'h0000_0000},
    '{32'h3000_0000, 32'h0000_0000, 4'b1111, 32'h0000_0000},
    '{32'h3000_0000, 32'h0000_0000, 4'b0000, 32'h0000_0000}
  };

  logic        clk;
  logic        rst;
  logic        bus_valid;
  logic [31:0] bus_addr;
  logic [31:0] bus_wdata;
  logic [3:0]  bus_wstrb;
  logic        bus_ready;
  logic [31:0] bus_rdata;
  logic        vid_hs;
  logic        vid_vs;
  logic        vid_de;
  logic [23:0] vid_rgb_in;
  logic [23:0] vid_rgb_out;

  // reference model state
  logic [7:0]  model_mem [2048];
  logic        exp_en;
  logic [31:0] lfsr;
  int          n_checks;
  int          err_val;
  int          err_other;

  osd_top #(
    .FG_RGB (FG),
    .BG_RGB (BG)
  ) uut (
    .clk         (clk),
    .rst         (rst),
    .i_bus_valid (bus_valid),
    .i_bus_addr  (bus_addr),
    .i_bus_wdata (bus_wdata),
    .i_bus_wstrb (bus_wstrb),
    .o_bus_ready (bus_ready),
    .o_bus_rdata (bus_rdata),
    .i_vid_hs    (vid_hs),
    .i_vid_vs    (vid_vs),
    .i_vid_de    (vid_de),
    .i_vid_rgb   (vid_rgb_in),
    .o_vid_rgb   (vid_rgb_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // random bits and model lookups
  //////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [31:0] model_word(input logic [8:0] w);
    return {model_mem[{w, 2'd3}], model_mem[{w, 2'd2}],
            model_mem[{w, 2'd1}], model_mem[{w, 2'd0}]};
  endfunction

  // byte g shows from x = 8g+2 and the last two bits of byte g-1 lead it
  function automatic logic [23:0] expected_pixel(input int x, input int y,
                                                 input logic de, input logic [23:0] rgb);
    logic [4:0]  g;
    logic [2:0]  k;
    logic [2:0]  j;
    logic [7:0]  b;
    logic        bit_v;
    if (!de) begin
      return 24'd0;
    end
    if (!exp_en || y >= WIN_H || x >= WIN_W) begin
      return rgb;
    end
    g = x[7:3];
    k = x[2:0];
    // wraps to 7-(k-2) for this byte and to 1-k for the previous one
    j = 3'd1 - k;
    if (k >= 3'd2) begin
      b = model_mem[{y[5:0], g}];
      bit_v = b[j];
    end else if (g == 5'd0) begin
      bit_v = 1'b0;
    end else begin
      b = model_mem[{y[5:0], g - 5'd1}];
      bit_v = b[j];
    end
    return bit_v ? FG : BG;
  endfunction

  //////////////////////////////////////////////////
  // bus and video drivers
  //////////////////////////////////////////////////

  task automatic bus_access(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [31:0] rdata);
    int   waited;
    logic seen;
    @(posedge clk);
    #1;
    bus_valid = 1'b1;
    bus_addr  = addr;
    bus_wdata = data;
    bus_wstrb = strb;
    waited = 0;
    seen   = 1'b0;
    rdata  = '0;
    while (!seen && waited < OP_BOUND) begin
      @(negedge clk);
      waited++;
      if (bus_ready) begin
        seen  = 1'b1;
        rdata = bus_rdata;
      end
    end
    if (!seen) begin
      $display("bus request to %h got no ready within %0d cycles", addr, OP_BOUND);
      err_other++;
    end else if (waited < 3) begin
      $display("bus request to %h was acknowledged too early", addr);
      err_other++;
    end
    @(posedge clk);
    #1;
    bus_valid = 1'b0;
    @(negedge clk);
    if (bus_ready) begin
      $display("bus request to %h got a second ready pulse", addr);
      err_other++;
    end
    if (seen && addr[31:28] == osd_pkg::REGION_RAM) begin
      for (int l = 0; l < 4; l++) begin
        if (strb[l]) begin
          model_mem[{addr[10:2], 2'(l)}] = data[l*8 +: 8];
        end
      end
    end
    if (seen && addr == osd_pkg::ADDR_OSD_CTRL && strb == 4'b1111) begin
      exp_en = data[0];
    end
  endtask

  task automatic video_cycle(input logic hs, input logic vs, input logic de,
                             input logic [23:0] rgb, input int x, input int y);
    logic [23:0] exp_rgb;
    @(posedge clk);
    #1;
    vid_hs     = hs;
    vid_vs     = vs;
    vid_de     = de;
    vid_rgb_in = rgb;
    @(negedge clk);
    exp_rgb = expected_pixel(x, y, de, rgb);
    n_checks++;
    if (vid_rgb_out !== exp_rgb) begin
      $display("ERR %0t: pixel x=%0d y=%0d got %h expected %h",
               $time, x, y, vid_rgb_out, exp_rgb);
      err_val++;
    end
  endtask

  // vsync and then lines of pixels closed by hsync and blanking
  task automatic run_frame();
    logic [31:0] r;
    video_cycle(1'b0, 1'b1, 1'b0, 24'd0, 0, 0);
    for (int line = 0; line < LINES; line++) begin
      for (int px = 0; px < PIX; px++) begin
        draw_bits(24, r);
        video_cycle(1'b0, 1'b0, 1'b1, r[23:0], px, line);
      end
      video_cycle(1'b1, 1'b0, 1'b0, 24'd0, 0, line);
      repeat (3) video_cycle(1'b0, 1'b0, 1'b0, 24'd0, 0, line);
    end
  endtask

  // spread over the first window lines to hit fetch stalls
  task automatic reads_in_window();
    logic [31:0] rd;
    logic [8:0]  w;
    repeat (20) @(posedge clk);
    for (int i = 0; i < N_READS; i++) begin
      w = 9'((i * 37 + 5) % int'(osd_pkg::OSD_WORDS));
      bus_access({osd_pkg::REGION_RAM, 17'd0, w, 2'b00}, 32'd0, 4'b0000, rd);
      n_checks++;
      if (rd !== model_word(w)) begin
        $display("ERR %0t: ram word %0d read %h expected %h", $time, w, rd, model_word(w));
        err_val++;
      end
      repeat (29) @(posedge clk);
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    logic [31:0] d;
    rst        = 1'b1;
    bus_valid  = 1'b0;
    bus_addr   = '0;
    bus_wdata  = '0;
    bus_wstrb  = '0;
    vid_hs     = 1'b0;
    vid_vs     = 1'b0;
    vid_de     = 1'b0;
    vid_rgb_in = '0;
    exp_en     = 1'b0;
    lfsr       = 32'hf45b_a62e;
    n_checks   = 0;
    err_val    = 0;
    err_other  = 0;
    for (int i = 0; i < 2048; i++) begin
      model_mem[i] = 8'd0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;

    // plain picture pass-through
    run_frame();

    for (int i = 0; i < N_OPS; i++) begin
      bus_access(OPS[i].addr, OPS[i].data, OPS[i].strb, rd);
      if (OPS[i].strb == 4'b0000) begin
        n_checks++;
        if (rd !== OPS[i].exp) begin
          $display("ERR %0t: op %0d read %h from %h expected %h",
                   $time, i, rd, OPS[i].addr, OPS[i].exp);
          err_val++;
        end
      end
    end

    // random bitmap and then the overlay
    for (int w = 0; w < int'(osd_pkg::OSD_WORDS); w++) begin
      draw_bits(32, d);
      bus_access({osd_pkg::REGION_RAM, 17'd0, 9'(w), 2'b00}, d, 4'b1111, rd);
    end
    bus_access(osd_pkg::ADDR_OSD_CTRL, 32'd1, 4'b1111, rd);
    run_frame();

    fork
      run_frame();
      reads_in_window();
    join

    bus_access(osd_pkg::ADDR_OSD_CTRL, 32'd0, 4'b1111, rd);
    run_frame();

    $display("checks %0d, value errors %0d, other failures %0d",
             n_checks, err_val, err_other);
    if (err_val == 0 && err_other == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the run did not finish within %0d cycles", WD_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- design/osd_top.sv
//////////////////////////////////////////////////
// osd top level, bus in and video through with
// the osd bitmap overlaid at the top-left corner
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module osd_top #(
  parameter logic [osd_pkg::RGB_W-1:0] FG_RGB = osd_pkg::OSD_FG_RGB,
  parameter logic [osd_pkg::RGB_W-1:0] BG_RGB = osd_pkg::OSD_BG_RGB
) (
  input  wire                        clk,
  input  wire                        rst,
  // request bus
  input  wire                        i_bus_valid,
  input  wire  [31:0]                i_bus_addr,
  input  wire  [31:0]                i_bus_wdata,
  input  wire  [3:0]                 i_bus_wstrb,
  output logic                       o_bus_ready,
  output logic [31:0]                o_bus_rdata,
  // video
  input  wire                        i_vid_hs,
  input  wire                        i_vid_vs,
  input  wire                        i_vid_de,
  input  wire  [osd_pkg::RGB_W-1:0]  i_vid_rgb,
  output logic [osd_pkg::RGB_W-1:0]  o_vid_rgb
);

  osd_pkg::osd_addr_u fetch_addr;
  logic               fetch;
  logic               fetch_busy;
  logic               in_window;
  logic               osd_en;
  logic               ram_req;
  logic [8:0]         ram_word;
  logic [3:0]         ram_wstrb;
  logic [31:0]        ram_rdata;

  osd_raster u_raster (
    .clk          (clk),
    .rst          (rst),
    .i_vid_hs     (i_vid_hs),
    .i_vid_vs     (i_vid_vs),
    .i_vid_de     (i_vid_de),
    .i_osd_en     (osd_en),
    .o_in_window  (in_window),
    .o_fetch      (fetch),
    .o_fetch_addr (fetch_addr)
  );

  // one read port feeds both the bus and the mixer
  osd_ram u_ram (
    .clk          (clk),
    .i_fetch      (fetch),
    .i_fetch_addr (fetch_addr),
    .i_bus_req    (ram_req),
    .i_bus_word   (ram_word),
    .i_bus_wstrb  (ram_wstrb),
    .i_bus_wdata  (i_bus_wdata),
    .o_rdata      (ram_rdata),
    .o_fetch_busy (fetch_busy)
  );

  osd_bus_regs u_bus_regs (
    .clk          (clk),
    .rst          (rst),
    .i_bus_valid  (i_bus_valid),
    .i_bus_addr   (i_bus_addr),
    .i_bus_wdata  (i_bus_wdata),
    .i_bus_wstrb  (i_bus_wstrb),
    .i_ram_rdata  (ram_rdata),
    .i_fetch_busy (fetch_busy),
    .o_bus_ready  (o_bus_ready),
    .o_bus_rdata  (o_bus_rdata),
    .o_ram_req    (ram_req),
    .o_ram_word   (ram_word),
    .o_ram_wstrb  (ram_wstrb),
    .o_osd_en     (osd_en)
  );

  osd_pixel_mixer #(
    .FG_RGB (FG_RGB),
    .BG_RGB (BG_RGB)
  ) u_mixer (
    .clk          (clk),
    .rst          (rst),
    .i_fetch      (fetch),
    .i_fetch_addr (fetch_addr),
    .i_fetch_data (ram_rdata),
    .i_in_window  (in_window),
    .i_vid_de     (i_vid_de),
    .i_vid_rgb    (i_vid_rgb),
    .o_vid_rgb    (o_vid_rgb)
  );

endmodule

`default_nettype wire

//--- design/osd_pixel_mixer.sv
//////////////////////////////////////////////////
// picks the fetched bitmap byte, shifts it out one
// pixel per clock and lays the osd colours over
// the incoming picture inside the window
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module osd_pixel_mixer #(
  parameter logic [osd_pkg::RGB_W-1:0] FG_RGB = osd_pkg::OSD_FG_RGB,
  parameter logic [osd_pkg::RGB_W-1:0] BG_RGB = osd_pkg::OSD_BG_RGB
) (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         i_fetch,
  input  osd_pkg::osd_addr_u          i_fetch_addr,
  input  wire  [31:0]                 i_fetch_data,
  input  wire                         i_in_window,
  input  wire                         i_vid_de,
  input  wire  [osd_pkg::RGB_W-1:0]   i_vid_rgb,
  output logic [osd_pkg::RGB_W-1:0]   o_vid_rgb
);

  logic       fetch_q;
  logic [1:0] lane_q;
  logic [7:0] fetch_byte;
  logic [7:0] pix_shift;

  // line up with the ram read latency
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_q <= 1'b0;
    end else begin
      fetch_q <= i_fetch;
    end
  end

  always_ff @(posedge clk) begin
    lane_q <= i_fetch_addr.mem.lane;
  end

  // lane select from the 32-bit word
  always_comb begin
    case (lane_q)
      2'd0:    fetch_byte = i_fetch_data[7:0];
      2'd1:    fetch_byte = i_fetch_data[15:8];
      2'd2:    fetch_byte = i_fetch_data[23:16];
      default: fetch_byte = i_fetch_data[31:24];
    endcase
  end

  //////////////////////////////////////////////////
  // pixel shifter, msb is the leftmost pixel
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      pix_shift <= 8'd0;
    end else if (fetch_q) begin
      pix_shift <= fetch_byte;
    end else begin
      pix_shift <= {pix_shift[6:0], 1'b0};
    end
  end

  // blank outside active video
  always_comb begin
    if (!i_vid_de) begin
      o_vid_rgb = '0;
    end else if (i_in_window) begin
      o_vid_rgb = pix_shift[7] ? FG_RGB : BG_RGB;
    end else begin
      o_vid_rgb = i_vid_rgb;
    end
  end

endmodule

`default_nettype wire

//--- design/osd_bus_regs.sv
//////////////////////////////////////////////////
// bus side of the osd, decodes the address region,
// holds the enable register, drives the bitmap ram
// port and returns read data with a ready pulse
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module osd_bus_regs (
  input  wire         clk,
  input  wire         rst,
  input  wire         i_bus_valid,
  input  wire  [31:0] i_bus_addr,
  input  wire  [31:0] i_bus_wdata,
  input  wire  [3:0]  i_bus_wstrb,
  input  wire  [31:0] i_ram_rdata,
  input  wire         i_fetch_busy,
  output logic        o_bus_ready,
  output logic [31:0] o_bus_rdata,
  output logic        o_ram_req,
  output logic [8:0]  o_ram_word,
  output logic [3:0]  o_ram_wstrb,
  output logic        o_osd_en
);

  logic [3:0] region;
  logic       is_ram;
  logic       is_reg;
  logic       is_ctrl;
  logic       pend;
  logic       start;
  logic       accept;

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////

  assign region  = i_bus_addr[31:28];
  assign is_ram  = (region == osd_pkg::REGION_RAM);
  assign is_reg  = (region == osd_pkg::REGION_REG);
  assign is_ctrl = is_reg && (i_bus_addr[27:0] == osd_pkg::ADDR_OSD_CTRL[27:0]);

  //////////////////////////////////////////////////
  // request handshake
  //////////////////////////////////////////////////

  // new request, the ready cycle still shows the old one
  assign start = i_bus_valid && !pend && !o_bus_ready;

  // ram waits out every raster fetch cycle
  assign accept = i_bus_valid && pend && !(is_ram && i_fetch_busy);

  always_ff @(posedge clk) begin
    if (rst) begin
      pend        <= 1'b0;
      o_bus_ready <= 1'b0;
    end else begin
      pend        <= start || (pend && i_bus_valid && !accept);
      o_bus_ready <= accept;
    end
  end

  //////////////////////////////////////////////////
  // enable register
  //////////////////////////////////////////////////

  // full word writes only
  always_ff @(posedge clk) begin
    if (rst) begin
      o_osd_en <= 1'b0;
    end else if (accept && is_ctrl && (i_bus_wstrb == 4'b1111)) begin
      o_osd_en <= i_bus_wdata[0];
    end
  end

  //////////////////////////////////////////////////
  // ram port and read data
  //////////////////////////////////////////////////

  assign o_ram_req   = accept && is_ram;
  assign o_ram_word  = i_bus_addr[10:2];
  assign o_ram_wstrb = i_bus_wstrb;

  // address is still held while ready is high
  always_comb begin
    if (is_ram) begin
      o_bus_rdata = i_ram_rdata;
    end else if (is_ctrl) begin
      o_bus_rdata = {31'd0, o_osd_en};
    end else begin
      // unmapped reads as zero
      o_bus_rdata = 32'd0;
    end
  end

endmodule

`default_nettype wire

//--- design/osd_ram.sv
//////////////////////////////////////////////////
// 2 KB osd bitmap in four byte lanes behind one
// registered port, the raster fetch wins over the
// bus and never writes
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module osd_ram (
  input  wire                clk,
  input  wire                i_fetch,
  input  osd_pkg::osd_addr_u i_fetch_addr,
  input  wire                i_bus_req,
  input  wire  [8:0]         i_bus_word,
  input  wire  [3:0]         i_bus_wstrb,
  input  wire  [31:0]        i_bus_wdata,
  output logic [31:0]        o_rdata,
  output logic               o_fetch_busy
);

  logic [8:0] word_addr;
  logic       port_en;
  logic [3:0] lane_we;

  //////////////////////////////////////////////////
  // port arbitration
  //////////////////////////////////////////////////

  // fetch address has priority
  assign word_addr = i_fetch ? i_fetch_addr.mem.word : i_bus_word;

  // hold the last read data when idle
  assign port_en = i_fetch || i_bus_req;

  // byte writes only on bus cycles
  assign lane_we = (i_bus_req && !i_fetch) ? i_bus_wstrb : 4'b0000;

  // tells the bus block this cycle is taken
  assign o_fetch_busy = i_fetch;

  //////////////////////////////////////////////////
  // byte lanes
  //////////////////////////////////////////////////

  for (genvar g = 0; g < 4; g++) begin : g_lane
    logic [7:0] mem [osd_pkg::OSD_WORDS];

    always_ff @(posedge clk) begin
      if (lane_we[g]) begin
        mem[word_addr] <= i_bus_wdata[g*8 +: 8];
      end
    end

    // registered read, old data on a write cycle
    always_ff @(posedge clk) begin
      if (port_en) begin
        o_rdata[g*8 +: 8] <= mem[word_addr];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/osd_raster.sv
//////////////////////////////////////////////////
// follows the incoming video timing and flags
// pixels inside the osd window, one bitmap fetch
// is requested for every eight window pixels
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module osd_raster (
  input  wire               clk,
  input  wire               rst,
  input  wire               i_vid_hs,
  input  wire               i_vid_vs,
  input  wire               i_vid_de,
  input  wire               i_osd_en,
  output logic              o_in_window,
  output logic              o_fetch,
  output osd_pkg::osd_addr_u o_fetch_addr
);

  // window limits at counter width
  localparam logic [8:0] X_LIM = 9'(osd_pkg::OSD_W_PIX);
  localparam logic [8:0] Y_LIM = 9'(osd_pkg::OSD_H_PIX);

  logic [8:0] x_cnt;
  logic [8:0] y_cnt;

  //////////////////////////////////////////////////
  // raster position
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      x_cnt <= '0;
      y_cnt <= '0;
    end else if (i_vid_vs) begin
      y_cnt <= '0;
    end else if (i_vid_hs) begin
      x_cnt <= '0;
      // only count lines that carried pixels
      if (x_cnt != '0) begin
        y_cnt <= y_cnt + 9'd1;
      end
    end else if (i_vid_de) begin
      x_cnt <= x_cnt + 9'd1;
    end
  end

  //////////////////////////////////////////////////
  // window and fetch
  //////////////////////////////////////////////////

  assign o_in_window = i_osd_en && i_vid_de && (y_cnt < Y_LIM) && (x_cnt < X_LIM);

  // first pixel of each column byte
  assign o_fetch = o_in_window && (x_cnt[2:0] == 3'd0);

  always_comb begin
    o_fetch_addr.pix.row = y_cnt[5:0];
    o_fetch_addr.pix.col = x_cnt[7:3];
  end

endmodule

`default_nettype wire

//--- design/osd_pkg.sv
//////////////////////////////////////////////////
// shared types and constants for the osd path
// referenced by scoped name from every rtl module
//////////////////////////////////////////////////

`default_nettype none

package osd_pkg;

  //////////////////////////////////////////////////
  // bitmap byte address, two views of one word
  //////////////////////////////////////////////////

  // pixel view, row within the window and x / 8
  typedef struct packed {
    logic [5:0] row;
    logic [4:0] col;
  } osd_pix_t;

  // memory view, 32-bit word and byte lane
  typedef struct packed {
    logic [8:0] word;
    logic [1:0] lane;
  } osd_mem_t;

  typedef union packed {
    osd_pix_t pix;
    osd_mem_t mem;
  } osd_addr_u;

  //////////////////////////////////////////////////
  // memory map
  //////////////////////////////////////////////////

  // bitmap ram depth in 32-bit words
  localparam int unsigned OSD_WORDS = 512;

  // top address nibble
  localparam logic [3:0] REGION_RAM = 4'h1;
  localparam logic [3:0] REGION_REG = 4'h3;

  // enable register, bit 0 only
  localparam logic [31:0] ADDR_OSD_CTRL = {REGION_REG, 28'h000_0000};

  //////////////////////////////////////////////////
  // window and colour
  //////////////////////////////////////////////////

  // window in pixels, top-left corner of the frame
  localparam int unsigned OSD_W_PIX = 256;
  localparam int unsigned OSD_H_PIX = 64;

  localparam int unsigned RGB_W = 24;

  // white text on a dark slate background
  localparam logic [RGB_W-1:0] OSD_FG_RGB = 24'hff_ff_ff;
  localparam logic [RGB_W-1:0] OSD_BG_RGB = 24'h30_40_50;

endpackage

`default_nettype wire
